//--- hdl/mem_stage_params.svh
// ==========================================================
// Memory stage parameters
// Data width, write queue depth and bus wait limits
// ==========================================================
`ifndef MEM_STAGE_PARAMS_SVH
`define MEM_STAGE_PARAMS_SVH

`define MS_DATA_W 32
`define MS_WQ_DEPTH 4

// Longest APB stall the memory model produces
`define MS_MAX_WAIT 3

`endif

//--- hdl/mem_stage_pkg.sv
// ==========================================================
// Memory stage types
// Operation and width encodings and the write queue entry
// ==========================================================
`include "mem_stage_params.svh"

package mem_stage_pkg;

	typedef enum logic [1:0] {
		op_none,
		op_load,
		op_store,
		op_flush
	} mem_op_t;

	typedef enum logic [1:0] {
		width_byte,
		width_half,
		width_word
	} mem_width_t;

	// Word address, lane data and byte strobes of one posted write
	typedef struct packed {
		logic [`MS_DATA_W-3:0] addr;
		logic [`MS_DATA_W-1:0] data;
		logic [3:0] mask;
	} wq_entry_t;

	typedef logic [4:0] reg_index_t;

endpackage

//--- hdl/mem_access.sv
// ==========================================================
// Memory access stage
// Takes one toggle-strobed operation at a time, aligns store
// lanes, extends load data and waits out flushes
// ==========================================================
`timescale 1ns/1ps
`include "mem_stage_params.svh"

module mem_access import mem_stage_pkg::*; (
	input logic i_clock,
	input logic i_rst_n,

	// Execute side
	input logic i_req_strobe,
	input mem_op_t i_op,
	input mem_width_t i_width,
	input logic i_signed,
	input logic [`MS_DATA_W-1:0] i_address,
	input logic [`MS_DATA_W-1:0] i_wdata,
	input logic [`MS_DATA_W-1:0] i_pc,
	input reg_index_t i_rd_index,
	output logic o_busy,

	// Result
	output logic o_res_strobe,
	output logic [`MS_DATA_W-1:0] o_res_pc,
	output logic [`MS_DATA_W-1:0] o_res_rd,
	output reg_index_t o_res_rd_index,

	// Write queue side
	output logic q_request,
	output logic q_write,
	output logic [`MS_DATA_W-3:0] q_address,
	output logic [`MS_DATA_W-1:0] q_wdata,
	output logic [3:0] q_mask,
	input logic q_ready,
	input logic [`MS_DATA_W-1:0] q_rdata,
	input logic q_pending
);

	typedef enum logic {
		st_idle,
		st_flush
	} ma_state_t;

	ma_state_t state;
	ma_state_t next_state;
	logic last_strobe;
	logic offer;
	logic complete;
	logic [1:0] byte_offset;
	logic [`MS_DATA_W-1:0] shifted_rdata;
	logic [`MS_DATA_W-1:0] load_data;
	logic [`MS_DATA_W-1:0] res_data;

	assign offer = (i_req_strobe != last_strobe);
	assign o_busy = offer && (i_op != op_none);

	assign byte_offset = i_address[1:0];
	assign q_address = i_address[`MS_DATA_W-1:2];

	// ==========================================================
	// Lane alignment

	assign shifted_rdata = q_rdata >> {byte_offset, 3'b000};

	always_comb begin
		case (i_width)
			width_byte: load_data = {{24{i_signed & shifted_rdata[7]}}, shifted_rdata[7:0]};
			width_half: load_data = {{16{i_signed & shifted_rdata[15]}}, shifted_rdata[15:0]};
			default: load_data = q_rdata;
		endcase
	end

	// Odd halfword offsets leave the mask empty
	always_comb begin
		q_wdata = '0;
		q_mask = 4'b0000;
		case (i_width)
			width_word: begin
				q_wdata = i_wdata;
				q_mask = 4'b1111;
			end
			width_half: begin
				if (!byte_offset[0]) begin
					q_wdata = `MS_DATA_W'(i_wdata[15:0]) << {byte_offset, 3'b000};
					q_mask = 4'b0011 << byte_offset;
				end
			end
			width_byte: begin
				q_wdata = `MS_DATA_W'(i_wdata[7:0]) << {byte_offset, 3'b000};
				q_mask = 4'b0001 << byte_offset;
			end
			default: begin
				q_mask = 4'b0000;
			end
		endcase
	end

	// ==========================================================
	// Sequencing

	always_comb begin
		next_state = state;
		complete = 1'b0;
		q_request = 1'b0;
		q_write = 1'b0;
		res_data = i_wdata;

		case (state)
			st_idle: begin
				if (offer) begin
					case (i_op)
						op_load: begin
							q_request = 1'b1;
							complete = q_ready;
							res_data = load_data;
						end
						op_store: begin
							q_request = 1'b1;
							q_write = 1'b1;
							complete = q_ready;
						end
						op_flush: begin
							if (q_pending) begin
								next_state = st_flush;
							end else begin
								complete = 1'b1;
							end
						end
						default: begin
							complete = 1'b1;
						end
					endcase
				end
			end
			st_flush: begin
				if (!q_pending) begin
					complete = 1'b1;
					next_state = st_idle;
				end
			end
			default: begin
				next_state = st_idle;
			end
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state <= st_idle;
			last_strobe <= 1'b0;
			o_res_strobe <= 1'b0;
		end else begin
			state <= next_state;
			if (complete) begin
				last_strobe <= i_req_strobe;
				o_res_strobe <= ~o_res_strobe;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (complete) begin
			o_res_pc <= i_pc;
			o_res_rd <= res_data;
			o_res_rd_index <= i_rd_index;
		end
	end

endmodule

//--- hdl/write_queue.sv
// ==========================================================
// Posted write queue
// Buffers stores ahead of the bus and lets reads through
// only once every queued write has drained
// ==========================================================
`timescale 1ns/1ps
`include "mem_stage_params.svh"

module write_queue import mem_stage_pkg::*; #(
	parameter int DEPTH = `MS_WQ_DEPTH
) (
	input logic i_clock,
	input logic i_rst_n,

	// Stage side
	input logic q_request,
	input logic q_write,
	input logic [`MS_DATA_W-3:0] q_address,
	input logic [`MS_DATA_W-1:0] q_wdata,
	input logic [3:0] q_mask,
	output logic q_ready,
	output logic [`MS_DATA_W-1:0] q_rdata,
	output logic q_pending,

	// Bus side
	output logic b_request,
	output logic b_write,
	output logic [`MS_DATA_W-3:0] b_address,
	output logic [`MS_DATA_W-1:0] b_wdata,
	output logic [3:0] b_mask,
	input logic b_ready,
	input logic [`MS_DATA_W-1:0] b_rdata
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	wq_entry_t entries [DEPTH];
	wq_entry_t head_entry;
	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [CNT_W-1:0] count;
	logic empty;
	logic full;
	logic push;
	logic pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			next_ptr = '0;
		end else begin
			next_ptr = ptr + 1'b1;
		end
	endfunction

	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));
	assign head_entry = entries[head];

	// Empty-mask writes are acknowledged and dropped
	assign push = q_request && q_write && !full && (q_mask != 4'b0000);
	assign pop = !empty && b_ready;

	assign q_ready = q_write ? !full : (empty && b_ready);
	assign q_rdata = b_rdata;
	assign q_pending = !empty;

	// Head write first; a read only goes out on an empty queue
	assign b_request = !empty || (q_request && !q_write);
	assign b_write = !empty;
	assign b_address = empty ? q_address : head_entry.addr;
	assign b_wdata = head_entry.data;
	assign b_mask = empty ? 4'b0000 : head_entry.mask;

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (push) begin
				tail <= next_ptr(tail);
			end
			if (pop) begin
				head <= next_ptr(head);
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (push) begin
			entries[tail] <= '{addr: q_address, data: q_wdata, mask: q_mask};
		end
	end

endmodule

//--- hdl/apb_master.sv
// ==========================================================
// APB requester
// Turns one request/ready transfer into setup and access
// ==========================================================
`timescale 1ns/1ps
`include "mem_stage_params.svh"

module apb_master (
	input logic i_clock,
	input logic i_rst_n,

	// Queue side
	input logic b_request,
	input logic b_write,
	input logic [`MS_DATA_W-3:0] b_address,
	input logic [`MS_DATA_W-1:0] b_wdata,
	input logic [3:0] b_mask,
	output logic b_ready,
	output logic [`MS_DATA_W-1:0] b_rdata,

	// APB
	output logic o_psel,
	output logic o_penable,
	output logic o_pwrite,
	output logic [`MS_DATA_W-1:0] o_paddr,
	output logic [`MS_DATA_W-1:0] o_pwdata,
	output logic [3:0] o_pstrb,
	input logic i_pready,
	input logic [`MS_DATA_W-1:0] i_prdata
);

	typedef enum logic [1:0] {
		st_idle,
		st_setup,
		st_access
	} apb_state_t;

	apb_state_t state;

	assign o_psel = (state != st_idle);
	assign o_penable = (state == st_access);
	assign b_ready = o_penable && i_pready;
	assign b_rdata = i_prdata;

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: if (b_request) state <= st_setup;
				st_setup: state <= st_access;
				st_access: if (i_pready) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	// Captured once and held through any wait states
	always_ff @(posedge i_clock) begin
		if (state == st_idle && b_request) begin
			o_pwrite <= b_write;
			o_paddr <= {b_address, 2'b00};
			o_pwdata <= b_wdata;
			o_pstrb <= b_write ? b_mask : 4'b0000;
		end
	end

endmodule

//--- hdl/mem_stage_top.sv
// ==========================================================
// Memory stage top
// Access stage, posted write queue and APB requester
// ==========================================================
`timescale 1ns/1ps
`include "mem_stage_params.svh"

module mem_stage_top import mem_stage_pkg::*; (
	input logic i_clock,
	input logic i_rst_n,

	// Execute side
	input logic i_req_strobe,
	input mem_op_t i_op,
	input mem_width_t i_width,
	input logic i_signed,
	input logic [`MS_DATA_W-1:0] i_address,
	input logic [`MS_DATA_W-1:0] i_wdata,
	input logic [`MS_DATA_W-1:0] i_pc,
	input reg_index_t i_rd_index,
	output logic o_busy,
	output logic o_res_strobe,
	output logic [`MS_DATA_W-1:0] o_res_pc,
	output logic [`MS_DATA_W-1:0] o_res_rd,
	output reg_index_t o_res_rd_index,

	// APB
	output logic o_psel,
	output logic o_penable,
	output logic o_pwrite,
	output logic [`MS_DATA_W-1:0] o_paddr,
	output logic [`MS_DATA_W-1:0] o_pwdata,
	output logic [3:0] o_pstrb,
	input logic i_pready,
	input logic [`MS_DATA_W-1:0] i_prdata
);

	logic q_request;
	logic q_write;
	logic [`MS_DATA_W-3:0] q_address;
	logic [`MS_DATA_W-1:0] q_wdata;
	logic [3:0] q_mask;
	logic q_ready;
	logic [`MS_DATA_W-1:0] q_rdata;
	logic q_pending;

	logic b_request;
	logic b_write;
	logic [`MS_DATA_W-3:0] b_address;
	logic [`MS_DATA_W-1:0] b_wdata;
	logic [3:0] b_mask;
	logic b_ready;
	logic [`MS_DATA_W-1:0] b_rdata;

	mem_access u_access (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_req_strobe(i_req_strobe),
		.i_op(i_op),
		.i_width(i_width),
		.i_signed(i_signed),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.i_pc(i_pc),
		.i_rd_index(i_rd_index),
		.o_busy(o_busy),
		.o_res_strobe(o_res_strobe),
		.o_res_pc(o_res_pc),
		.o_res_rd(o_res_rd),
		.o_res_rd_index(o_res_rd_index),
		.q_request(q_request),
		.q_write(q_write),
		.q_address(q_address),
		.q_wdata(q_wdata),
		.q_mask(q_mask),
		.q_ready(q_ready),
		.q_rdata(q_rdata),
		.q_pending(q_pending)
	);

	write_queue #(
		.DEPTH(`MS_WQ_DEPTH)
	) u_queue (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.q_request(q_request),
		.q_write(q_write),
		.q_address(q_address),
		.q_wdata(q_wdata),
		.q_mask(q_mask),
		.q_ready(q_ready),
		.q_rdata(q_rdata),
		.q_pending(q_pending),
		.b_request(b_request),
		.b_write(b_write),
		.b_address(b_address),
		.b_wdata(b_wdata),
		.b_mask(b_mask),
		.b_ready(b_ready),
		.b_rdata(b_rdata)
	);

	apb_master u_apb (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.b_request(b_request),
		.b_write(b_write),
		.b_address(b_address),
		.b_wdata(b_wdata),
		.b_mask(b_mask),
		.b_ready(b_ready),
		.b_rdata(b_rdata),
		.o_psel(o_psel),
		.o_penable(o_penable),
		.o_pwrite(o_pwrite),
		.o_paddr(o_paddr),
		.o_pwdata(o_pwdata),
		.o_pstrb(o_pstrb),
		.i_pready(i_pready),
		.i_prdata(i_prdata)
	);

endmodule

//--- bench/mem_stage_sva.sv
// ==========================================================
// Memory stage assertions
// APB phase order, stall stability and result strobes
// ==========================================================
`timescale 1ns/1ps
`include "mem_stage_params.svh"

module mem_stage_sva (
	input logic i_clock,
	input logic i_rst_n,
	input logic i_req_strobe,
	input logic o_res_strobe,
	input logic o_psel,
	input logic o_penable,
	input logic o_pwrite,
	input logic [`MS_DATA_W-1:0] o_paddr,
	input logic [`MS_DATA_W-1:0] o_pwdata,
	input logic [3:0] o_pstrb,
	input logic i_pready
);

	setup_then_access: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_psel && !o_penable |=> o_psel && o_penable)
		else $error("APB access phase did not follow a setup cycle");

	// Address, data and strobes held across wait states
	stall_stable: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_psel && o_penable && !i_pready |=> o_psel && o_penable && $stable(o_pwrite)
			&& $stable(o_paddr) && $stable(o_pwdata) && $stable(o_pstrb))
		else $error("APB signals changed while PREADY was low");

	// Offer pending while request and result strobes differ
	strobe_on_offer: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		$changed(o_res_strobe) |-> $past(i_req_strobe != o_res_strobe))
		else $error("Result strobe toggled with no operation offered");

endmodule

bind mem_stage_top mem_stage_sva u_sva (
	.i_clock(i_clock),
	.i_rst_n(i_rst_n),
	.i_req_strobe(i_req_strobe),
	.o_res_strobe(o_res_strobe),
	.o_psel(o_psel),
	.o_penable(o_penable),
	.o_pwrite(o_pwrite),
	.o_paddr(o_paddr),
	.o_pwdata(o_pwdata),
	.o_pstrb(o_pstrb),
	.i_pready(i_pready)
);

//--- bench/mem_stage_tb.sv
// ==========================================================
// Memory stage testbench
// Runs the stim file through the stage against an APB
// memory model with random wait states
// ==========================================================
`timescale 1ns/1ps
`include "mem_stage_params.svh"

module mem_stage_tb import mem_stage_pkg::*; ();

	localparam int NUM_OPS = 30;
	localparam int FIELDS = 6;
	localparam int WAIT_BITS = $clog2(`MS_MAX_WAIT + 1);
	localparam int CYCLE_LIMIT = NUM_OPS * (`MS_WQ_DEPTH + 1) * (`MS_MAX_WAIT + 2) + 100;

	logic i_clock;
	logic i_rst_n;
	logic i_req_strobe;
	mem_op_t i_op;
	mem_width_t i_width;
	logic i_signed;
	logic [`MS_DATA_W-1:0] i_address;
	logic [`MS_DATA_W-1:0] i_wdata;
	logic [`MS_DATA_W-1:0] i_pc;
	reg_index_t i_rd_index;
	logic o_busy;
	logic o_res_strobe;
	logic [`MS_DATA_W-1:0] o_res_pc;
	logic [`MS_DATA_W-1:0] o_res_rd;
	reg_index_t o_res_rd_index;
	logic o_psel;
	logic o_penable;
	logic o_pwrite;
	logic [`MS_DATA_W-1:0] o_paddr;
	logic [`MS_DATA_W-1:0] o_pwdata;
	logic [3:0] o_pstrb;
	logic i_pready;
	logic [`MS_DATA_W-1:0] i_prdata;

	logic [31:0] stim [NUM_OPS*FIELDS];
	logic [`MS_DATA_W-1:0] memory [64];
	logic [31:0] lfsr;
	int wait_left = 0;
	int write_count = 0;
	int cycles = 0;
	int word_errors = 0;
	int index_errors = 0;
	int pc_errors = 0;
	int busy_errors = 0;
	int count_errors = 0;

	mem_stage_top uut (.*);

	initial begin
		i_clock = 1'b0;
		forever #2 i_clock = ~i_clock;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0]) begin
			lfsr_step = (state >> 1) ^ 32'h80200003;
		end else begin
			lfsr_step = state >> 1;
		end
	endfunction

	task automatic draw_wait(output int waits);
		int b;
		waits = 0;
		for (b = 0; b < WAIT_BITS; b++) begin
			waits = waits * 2 + lfsr[0];
			lfsr = lfsr_step(lfsr);
		end
		if (waits > `MS_MAX_WAIT) begin
			waits = `MS_MAX_WAIT;
		end
	endtask

	// ==========================================================
	// APB memory model

	always @(negedge i_clock) begin
		if (!i_rst_n || !o_psel) begin
			i_pready <= 1'b0;
		end else if (!o_penable) begin
			draw_wait(wait_left);
			i_pready <= 1'b0;
		end else if (wait_left > 0) begin
			wait_left = wait_left - 1;
			i_pready <= 1'b0;
		end else begin
			i_pready <= 1'b1;
			i_prdata <= memory[o_paddr[7:2]];
			if (o_pwrite) begin
				for (int lane = 0; lane < 4; lane++) begin
					if (o_pstrb[lane]) begin
						memory[o_paddr[7:2]][lane*8 +: 8] = o_pwdata[lane*8 +: 8];
					end
				end
				write_count = write_count + 1;
			end
		end
	end

	// ==========================================================
	// Checks and reporting

	task automatic check_word(input string name, input logic [`MS_DATA_W-1:0] got,
			input logic [`MS_DATA_W-1:0] expected);
		if (got !== expected) begin
			$display("FAILED at %0t: %s got %h expected %h", $time, name, got, expected);
			word_errors++;
		end
	endtask

	task automatic check_index(input reg_index_t got, input reg_index_t expected);
		if (got !== expected) begin
			$display("FAILED at %0t: o_res_rd_index got %0d expected %0d", $time, got, expected);
			index_errors++;
		end
	endtask

	task automatic check_pc(input logic [`MS_DATA_W-1:0] got, input logic [`MS_DATA_W-1:0] expected);
		if (got !== expected) begin
			$display("FAILED at %0t: o_res_pc got %h expected %h", $time, got, expected);
			pc_errors++;
		end
	endtask

	task automatic check_busy(input logic got, input logic expected);
		if (got !== expected) begin
			$display("FAILED at %0t: o_busy got %b expected %b", $time, got, expected);
			busy_errors++;
		end
	endtask

	task automatic check_count(input int got, input int expected);
		if (got != expected) begin
			$display("FAILED at %0t: memory write count got %0d expected %0d", $time, got, expected);
			count_errors++;
		end
	endtask

	task automatic print_counts();
		$display("Error counts: result %0d, index %0d, pc %0d, busy %0d, write count %0d",
			word_errors, index_errors, pc_errors, busy_errors, count_errors);
	endtask

	always @(posedge i_clock) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: a result strobe never came within %0d cycles", CYCLE_LIMIT);
			print_counts();
			$display("Errors found");
			$finish;
		end
	end

	initial begin
		int n;
		int base;
		int stores_written;
		i_rst_n = 1'b0;
		i_req_strobe = 1'b0;
		i_op = op_none;
		i_width = width_word;
		i_signed = 1'b0;
		i_address = '0;
		i_wdata = '0;
		i_pc = '0;
		i_rd_index = '0;
		i_pready = 1'b0;
		i_prdata = '0;
		lfsr = 32'h32fc7ff7;
		stores_written = 0;
		for (n = 0; n < 64; n++) begin
			memory[n] = '0;
		end
		$readmemh("bench/mem_stage_stim.txt", stim);

		repeat (5) @(negedge i_clock);
		i_rst_n = 1'b1;

		for (n = 0; n < NUM_OPS; n++) begin
			base = n * FIELDS;
			i_op = mem_op_t'(stim[base][1:0]);
			i_width = mem_width_t'(stim[base+1][1:0]);
			i_signed = stim[base+2][0];
			i_address = stim[base+3];
			i_wdata = stim[base+4];
			i_pc = 32'h1000 + 32'(n * 4);
			i_rd_index = reg_index_t'(n);
			// Odd halfword stores carry no strobes and never reach the bus
			if (i_op == op_store && !(i_width == width_half && i_address[0])) begin
				stores_written++;
			end
			i_req_strobe = ~i_req_strobe;

			// Busy only while a memory operation is on offer
			#1;
			check_busy(o_busy, i_op != op_none);
			do @(negedge i_clock); while (o_res_strobe != i_req_strobe);

			check_busy(o_busy, 1'b0);
			check_word("o_res_rd", o_res_rd, stim[base+5]);
			check_pc(o_res_pc, i_pc);
			check_index(o_res_rd_index, i_rd_index);
			if (i_op == op_flush) begin
				check_count(write_count, stores_written);
			end
		end

		print_counts();
		if (word_errors + index_errors + pc_errors + busy_errors + count_errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- bench/mem_stage_stim.txt
// op width signed address wdata expected_result
// op 0 none 1 load 2 store 3 flush, width 0 byte 1 half 2 word
0 2 0 00000000 12345678 12345678
2 2 0 00000010 11223344 11223344
2 0 0 00000012 000000AA 000000AA
2 0 0 00000010 00000055 00000055
2 0 0 00000011 00000066 00000066
2 0 0 00000013 00000077 00000077
2 1 0 00000014 12348001 12348001
2 1 0 00000016 0000F00F 0000F00F
1 2 0 00000014 00000000 F00F8001
1 2 0 00000010 00000000 77AA6655
1 0 1 00000010 00000000 00000055
1 0 0 00000012 00000000 000000AA
1 0 1 00000012 00000000 FFFFFFAA
1 0 1 00000013 00000000 00000077
1 0 0 00000011 00000000 00000066
1 1 1 00000014 00000000 FFFF8001
1 1 0 00000016 00000000 0000F00F
1 1 1 00000016 00000000 FFFFF00F
2 2 0 00000020 AAAA0001 AAAA0001
2 2 0 00000024 BBBB0002 BBBB0002
2 2 0 00000028 CCCC0003 CCCC0003
2 2 0 0000002C DDDD0004 DDDD0004
2 2 0 00000020 CAFEF00D CAFEF00D
1 2 0 00000020 00000000 CAFEF00D
2 2 0 00000030 01010101 01010101
2 1 0 00000033 0000FFFF 0000FFFF
2 0 0 00000031 000000EE 000000EE
3 2 0 00000000 0BADF00D 0BADF00D
1 2 0 00000030 00000000 0101EE01
0 0 0 00000000 FEDCBA98 FEDCBA98

//--- all.f
+incdir+hdl
hdl/mem_stage_pkg.sv
hdl/mem_access.sv
hdl/write_queue.sv
hdl/apb_master.sv
hdl/mem_stage_top.sv
bench/mem_stage_sva.sv
bench/mem_stage_tb.sv

//--- Bender.yml
package:
  name: mem_stage

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mem_stage_pkg.sv
      - hdl/mem_access.sv
      - hdl/write_queue.sv
      - hdl/apb_master.sv
      - hdl/mem_stage_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - bench/mem_stage_sva.sv
      - bench/mem_stage_tb.sv
